//--- src/ma_pkg.sv
package ma_pkg;

    ////////////////////////////////////////
    // widths that carry a meaning
    ////////////////////////////////////////
    typedef logic [31:0] word_t;      // data or address word
    typedef logic [4:0]  reg_addr_t;  // register file address
    typedef logic [2:0]  wb_ctrl_t;   // write back control, carried through
    typedef logic [1:0]  ma_ctrl_t;   // memory access control
    typedef logic [4:0]  vic_index_t; // config register select
    typedef logic [3:0]  vic_data_t;  // config register value
    typedef logic [1:0]  credit_t;    // dcache credit count, 0..2

    // access codes on i_ma_ma
    localparam ma_ctrl_t MA_NONE  = 2'b00;
    localparam ma_ctrl_t MA_LOAD  = 2'b01;
    localparam ma_ctrl_t MA_STORE = 2'b10;

    // credits held by the stage after reset
    localparam credit_t DC_CREDITS = 2'd2;

    // top address nibble mapping onto the vic bank
    localparam logic [3:0] VIC_NIBBLE = 4'hF;

    ////////////////////////////////////////
    // access fsm
    ////////////////////////////////////////
    typedef enum logic [1:0] {
        ST_IDLE,        // new instruction, may issue at once
        ST_WAIT_CREDIT, // cache access blocked on credit
        ST_WAIT_RSP     // load issued, waiting for data
    } ma_state_t;

endpackage

//--- src/ma_credit_counter.sv
`timescale 1ns/10ps

module ma_credit_counter (
    input  logic            clk,
    input  logic            i_reset,
    input  logic            i_take,       // request issued this cycle
    input  logic            i_give,       // credit returned by the cache
    output ma_pkg::credit_t o_credits,
    output logic            o_has_credit
);

    ma_pkg::credit_t count;

    // up/down, saturating at both ends
    always_ff @(posedge clk) begin
        if (i_reset) begin
            count <= ma_pkg::DC_CREDITS; // cache starts with full buffer space
        end else begin
            if (i_take && !i_give) begin
                if (count != '0) begin
                    count <= count - 1'b1;
                end
            end else if (i_give && !i_take) begin
                if (count != ma_pkg::DC_CREDITS) begin
                    count <= count + 1'b1; // never above the limit
                end
            end
            // take and give together, count unchanged
        end
    end

    assign o_credits    = count;
    assign o_has_credit = (count != '0);

endmodule

//--- src/ma_access_fsm.sv
`timescale 1ns/10ps

module ma_access_fsm (
    input  logic             clk,
    input  logic             i_reset,
    input  ma_pkg::ma_ctrl_t i_ma_ma,      // access kind from ex
    input  logic             i_is_vic,     // address hits the vic bank
    input  logic             i_stall,      // hazard unit hold
    input  logic             i_has_credit,
    input  logic             i_rsp_valid,  // load data back from cache
    output logic             o_req_valid,  // also the credit take
    output logic             o_req_we,
    output logic             o_miss
);

    ma_pkg::ma_state_t state;
    ma_pkg::ma_state_t state_nxt;
    logic              is_load;
    logic              is_store;
    logic              cache_acc;

    assign is_load   = (i_ma_ma == ma_pkg::MA_LOAD);
    assign is_store  = (i_ma_ma == ma_pkg::MA_STORE);
    assign cache_acc = (is_load || is_store) && !i_is_vic; // vic goes around the cache

    always_ff @(posedge clk) begin
        if (i_reset) begin
            state <= ma_pkg::ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    ////////////////////////////////////////
    // next state, request and miss
    ////////////////////////////////////////
    always_comb begin
        state_nxt   = state;
        o_req_valid = 1'b0;
        o_miss      = 1'b0;
        case (state)
            ma_pkg::ST_IDLE: begin
                if (cache_acc) begin
                    if (!i_has_credit) begin
                        o_miss = 1'b1; // blocked, wait for cache space
                        if (!i_stall) begin
                            state_nxt = ma_pkg::ST_WAIT_CREDIT;
                        end
                    end else begin
                        o_miss = is_load; // a store is done on issue
                        if (!i_stall) begin
                            o_req_valid = 1'b1; // no new access under stall
                            if (is_load) begin
                                state_nxt = ma_pkg::ST_WAIT_RSP;
                            end
                        end
                    end
                end
            end
            ma_pkg::ST_WAIT_CREDIT: begin
                o_miss = 1'b1;
                if (i_has_credit && !i_stall) begin // held off while stalled
                    o_req_valid = 1'b1;
                    if (is_store) begin
                        o_miss    = 1'b0; // store completes here
                        state_nxt = ma_pkg::ST_IDLE;
                    end else begin
                        state_nxt = ma_pkg::ST_WAIT_RSP;
                    end
                end
            end
            ma_pkg::ST_WAIT_RSP: begin
                o_miss = !i_rsp_valid; // low in the cycle carrying the data
                if (i_rsp_valid) begin
                    state_nxt = ma_pkg::ST_IDLE;
                end
            end
            default: state_nxt = ma_pkg::ST_IDLE;
        endcase
    end

    assign o_req_we = o_req_valid && is_store;

endmodule

//--- src/ma_vic_regs.sv
`timescale 1ns/10ps

module ma_vic_regs (
    input  logic               clk,
    input  logic               i_reset,
    input  logic               i_we,
    input  ma_pkg::vic_index_t i_index,
    input  ma_pkg::vic_data_t  i_data,
    output ma_pkg::vic_data_t  o_data
);

    localparam int NUM_REGS = 32; // one per interrupt line

    ma_pkg::vic_data_t regs [NUM_REGS];

    ////////////////////////////////////////
    // write port
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (i_reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0; // all lines unconfigured
            end
        end else if (i_we) begin
            regs[i_index] <= i_data;
        end
    end

    // read port, same cycle
    assign o_data = regs[i_index];

endmodule

//--- src/ma_datapath.sv
`timescale 1ns/10ps

module ma_datapath (
    input  logic               clk,
    input  logic               i_reset,
    input  ma_pkg::wb_ctrl_t   i_ma_wb,
    input  ma_pkg::ma_ctrl_t   i_ma_ma,
    input  ma_pkg::word_t      i_ma_alu_rslt, // effective address
    input  ma_pkg::word_t      i_ma_rs2_val,
    input  ma_pkg::word_t      i_ma_pc,
    input  ma_pkg::word_t      i_ma_mux_wb,   // forwarded wb result
    input  ma_pkg::reg_addr_t  i_ma_rdst,
    input  logic               i_op1_mems,    // forward wb into store data
    input  logic               i_stall,
    input  logic               i_miss,
    input  ma_pkg::word_t      i_rsp_data,
    input  ma_pkg::vic_data_t  i_vic_rdata,
    output logic               o_is_vic,
    output logic               o_vic_we,
    output ma_pkg::vic_index_t o_vic_index,
    output ma_pkg::vic_data_t  o_vic_wdata,
    output ma_pkg::word_t      o_req_addr,
    output ma_pkg::word_t      o_req_wdata,
    output ma_pkg::word_t      o_ma_pc,
    output ma_pkg::word_t      o_ma_alu_rslt,
    output ma_pkg::word_t      o_ma_mem_out,
    output ma_pkg::reg_addr_t  o_ma_rdst,
    output ma_pkg::wb_ctrl_t   o_ma_wb
);

    ma_pkg::word_t store_data;
    ma_pkg::word_t load_data;

    ////////////////////////////////////////
    // store data and address decode
    ////////////////////////////////////////
    assign store_data = i_op1_mems ? i_ma_mux_wb : i_ma_rs2_val;

    assign o_is_vic    = (i_ma_alu_rslt[31:28] == ma_pkg::VIC_NIBBLE);
    assign o_vic_index = i_ma_alu_rslt[6:2]; // word addressed bank
    assign o_vic_wdata = store_data[3:0];
    assign o_vic_we    = o_is_vic && (i_ma_ma == ma_pkg::MA_STORE) && !i_stall;

    assign o_req_addr  = i_ma_alu_rslt;
    assign o_req_wdata = store_data;

    // load result, zero when nothing is read
    always_comb begin
        load_data = '0;
        if (i_ma_ma == ma_pkg::MA_LOAD) begin
            if (o_is_vic) begin
                load_data = {28'd0, i_vic_rdata}; // zero extend config value
            end else begin
                load_data = i_rsp_data;
            end
        end
    end

    ////////////////////////////////////////
    // ma/wb pipeline register
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_ma_pc       <= '0;
            o_ma_rdst     <= '0;
            o_ma_alu_rslt <= '0;
            o_ma_mem_out  <= '0;
            o_ma_wb       <= '0;
        end else if (!i_stall) begin // hold under stall
            o_ma_pc       <= i_ma_pc;
            o_ma_rdst     <= i_ma_rdst;
            o_ma_alu_rslt <= i_ma_alu_rslt;
            o_ma_mem_out  <= load_data;
            o_ma_wb       <= i_miss ? '0 : i_ma_wb; // bubble while waiting
        end
    end

endmodule

//--- src/stage_ma.sv
`timescale 1ns/10ps

module stage_ma (
    input  logic              clk,
    input  logic              i_reset,
    // from execute
    input  ma_pkg::wb_ctrl_t  i_ma_wb,
    input  ma_pkg::ma_ctrl_t  i_ma_ma,
    input  ma_pkg::word_t     i_ma_alu_rslt,
    input  ma_pkg::word_t     i_ma_rs2_val,
    input  ma_pkg::word_t     i_ma_pc,
    input  ma_pkg::reg_addr_t i_ma_rdst,
    input  ma_pkg::word_t     i_ma_mux_wb,
    input  logic              i_op1_mems,
    input  logic              i_ma_stall,
    // dcache channel
    output logic              o_dc_req_valid,
    output logic              o_dc_req_we,
    output ma_pkg::word_t     o_dc_req_addr,
    output ma_pkg::word_t     o_dc_req_wdata,
    input  logic              i_dc_rsp_valid,
    input  ma_pkg::word_t     i_dc_rsp_data,
    input  logic              i_dc_credit,
    // to hazard unit and write back
    output logic              o_miss,
    output ma_pkg::word_t     o_ma_pc,
    output ma_pkg::reg_addr_t o_ma_rdst,
    output ma_pkg::word_t     o_ma_alu_rslt,
    output ma_pkg::wb_ctrl_t  o_ma_wb,
    output ma_pkg::word_t     o_ma_mem_out
);

    logic               has_credit;
    logic               is_vic;
    logic               vic_we;
    ma_pkg::vic_index_t vic_index;
    ma_pkg::vic_data_t  vic_wdata;
    ma_pkg::vic_data_t  vic_rdata;

    ////////////////////////////////////////
    // flow control and sequencing
    ////////////////////////////////////////
    ma_credit_counter u_credit (
        .clk          (clk),
        .i_reset      (i_reset),
        .i_take       (o_dc_req_valid), // one credit per request
        .i_give       (i_dc_credit),
        .o_credits    (),
        .o_has_credit (has_credit)
    );

    ma_access_fsm u_fsm (
        .clk          (clk),
        .i_reset      (i_reset),
        .i_ma_ma      (i_ma_ma),
        .i_is_vic     (is_vic),
        .i_stall      (i_ma_stall),
        .i_has_credit (has_credit),
        .i_rsp_valid  (i_dc_rsp_valid),
        .o_req_valid  (o_dc_req_valid),
        .o_req_we     (o_dc_req_we),
        .o_miss       (o_miss)
    );

    ma_vic_regs u_vic (
        .clk     (clk),
        .i_reset (i_reset),
        .i_we    (vic_we),
        .i_index (vic_index),
        .i_data  (vic_wdata),
        .o_data  (vic_rdata)
    );

    ////////////////////////////////////////
    // data side and ma/wb register
    ////////////////////////////////////////
    ma_datapath u_dp (
        .clk           (clk),
        .i_reset       (i_reset),
        .i_ma_wb       (i_ma_wb),
        .i_ma_ma       (i_ma_ma),
        .i_ma_alu_rslt (i_ma_alu_rslt),
        .i_ma_rs2_val  (i_ma_rs2_val),
        .i_ma_pc       (i_ma_pc),
        .i_ma_mux_wb   (i_ma_mux_wb),
        .i_ma_rdst     (i_ma_rdst),
        .i_op1_mems    (i_op1_mems),
        .i_stall       (i_ma_stall),
        .i_miss        (o_miss),
        .i_rsp_data    (i_dc_rsp_data),
        .i_vic_rdata   (vic_rdata),
        .o_is_vic      (is_vic),
        .o_vic_we      (vic_we),
        .o_vic_index   (vic_index),
        .o_vic_wdata   (vic_wdata),
        .o_req_addr    (o_dc_req_addr),
        .o_req_wdata   (o_dc_req_wdata),
        .o_ma_pc       (o_ma_pc),
        .o_ma_alu_rslt (o_ma_alu_rslt),
        .o_ma_mem_out  (o_ma_mem_out),
        .o_ma_rdst     (o_ma_rdst),
        .o_ma_wb       (o_ma_wb)
    );

endmodule

//--- sim/stage_ma_assert.sv
`timescale 1ns/10ps

module stage_ma_assert (
    input logic            clk,
    input logic            i_reset,
    input logic            i_req,        // request toward the dcache
    input logic            i_has_credit,
    input ma_pkg::credit_t i_credits,
    input logic            i_miss
);

    int unsigned fail_count = 0; // summed into the closing error line

    ////////////////////////////////////////
    // credit flow control
    ////////////////////////////////////////
    req_has_credit: assert property (@(posedge clk) disable iff (i_reset)
        i_req |-> i_has_credit)
        else begin
            $error("dcache request issued with no credit left");
            fail_count++;
        end

    credit_in_range: assert property (@(posedge clk) disable iff (i_reset)
        i_credits <= ma_pkg::DC_CREDITS) // saturates at the reset value
        else begin
            $error("credit count above the reset value");
            fail_count++;
        end

    // no access pending right out of reset
    miss_low_after_reset: assert property (@(posedge clk) i_reset |=> !i_miss)
        else begin
            $error("o_miss high in the cycle after reset");
            fail_count++;
        end

endmodule

bind ma_access_fsm stage_ma_assert u_fsm_chk (
    .clk          (clk),
    .i_reset      (i_reset),
    .i_req        (o_req_valid),
    .i_has_credit (i_has_credit),
    .i_credits    (ma_pkg::DC_CREDITS), // count lives in the counter
    .i_miss       (o_miss)
);

bind ma_credit_counter stage_ma_assert u_credit_chk (
    .clk          (clk),
    .i_reset      (i_reset),
    .i_req        (i_take),
    .i_has_credit (o_has_credit),
    .i_credits    (count),
    .i_miss       (1'b0)
);

//--- sim/tb_stage_ma.sv
`timescale 1ns/10ps

module tb_stage_ma;

    localparam int MAX_CYCLES = 3000; // 200 ops x 12 worst case cycles plus margin

    logic              clk = 1'b0;
    logic              i_reset;
    ma_pkg::wb_ctrl_t  i_ma_wb;
    ma_pkg::ma_ctrl_t  i_ma_ma;
    ma_pkg::word_t     i_ma_alu_rslt;
    ma_pkg::word_t     i_ma_rs2_val;
    ma_pkg::word_t     i_ma_pc;
    ma_pkg::reg_addr_t i_ma_rdst;
    ma_pkg::word_t     i_ma_mux_wb;
    logic              i_op1_mems;
    logic              i_ma_stall;
    logic              o_dc_req_valid;
    logic              o_dc_req_we;
    ma_pkg::word_t     o_dc_req_addr;
    ma_pkg::word_t     o_dc_req_wdata;
    logic              i_dc_rsp_valid;
    ma_pkg::word_t     i_dc_rsp_data;
    logic              i_dc_credit;
    logic              o_miss;
    ma_pkg::word_t     o_ma_pc;
    ma_pkg::reg_addr_t o_ma_rdst;
    ma_pkg::word_t     o_ma_alu_rslt;
    ma_pkg::wb_ctrl_t  o_ma_wb;
    ma_pkg::word_t     o_ma_mem_out;

    int unsigned       seed = 32'hd1bf7389;
    int                errors = 0;
    int                cycle = 0;
    ma_pkg::word_t     shadow_mem [ma_pkg::word_t]; // expected memory, from the stimulus
    ma_pkg::word_t     cache_mem [ma_pkg::word_t];  // what the dut actually wrote
    ma_pkg::vic_data_t shadow_vic [32];
    int                credit_due [$];               // cycle each credit goes back
    int                rsp_due = -1;
    ma_pkg::word_t     rsp_word;
    int                outstanding = 0;              // requests minus credits given
    logic              withhold = 1'b0;
    logic              exp_pending = 1'b0;
    string             exp_name;
    ma_pkg::word_t     exp_pc;
    ma_pkg::word_t     exp_alu;
    ma_pkg::word_t     exp_mem;
    ma_pkg::reg_addr_t exp_rdst;
    ma_pkg::wb_ctrl_t  exp_wb;

    stage_ma u_dut (.*);

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Verification failed");
            $finish;
        end
    end

    function automatic int unsigned next_random();
        seed ^= seed << 13;
        seed ^= seed >> 17;
        seed ^= seed << 5;
        return seed;
    endfunction

    // contents of a word never written
    function automatic ma_pkg::word_t fill_word(ma_pkg::word_t addr);
        return {addr[15:0], addr[31:16]} ^ 32'h5a3c_96e1;
    endfunction

    // load result from the shadow copies, zero for anything else
    function automatic ma_pkg::word_t expected_mem_out(ma_pkg::ma_ctrl_t ma, ma_pkg::word_t addr);
        if (ma != ma_pkg::MA_LOAD) begin
            return '0;
        end
        if (addr[31:28] == 4'hF) begin
            return {28'd0, shadow_vic[addr[6:2]]}; // bank index in bits 6..2
        end
        return shadow_mem.exists(addr) ? shadow_mem[addr] : fill_word(addr);
    endfunction

    task automatic check_word(string name, ma_pkg::word_t exp, ma_pkg::word_t act);
        if (act !== exp) begin
            $display("FAIL %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_rdst(string name, ma_pkg::reg_addr_t exp, ma_pkg::reg_addr_t act);
        if (act !== exp) begin
            $display("FAIL %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_wb(string name, ma_pkg::wb_ctrl_t exp, ma_pkg::wb_ctrl_t act);
        if (act !== exp) begin
            $display("FAIL %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    ////////////////////////////////////////
    // dcache model
    ////////////////////////////////////////
    initial begin
        forever begin
            @(negedge clk);
            i_dc_rsp_valid = 1'b0;
            i_dc_credit    = 1'b0;
            if (rsp_due == cycle) begin
                i_dc_rsp_valid = 1'b1;
                i_dc_rsp_data  = rsp_word;
                rsp_due        = -1;
            end
            if (!withhold && credit_due.size() > 0 && credit_due[0] <= cycle) begin
                i_dc_credit = 1'b1; // one credit per cycle at most
                void'(credit_due.pop_front());
                outstanding--;
            end
            #5; // request outputs settled
            if (o_dc_req_valid) begin
                outstanding++;
                if (outstanding > int'(ma_pkg::DC_CREDITS)) begin
                    $display("dcache got more requests than it has credits");
                    errors++;
                end
                credit_due.push_back(cycle + 1 + int'(next_random() % 3));
                if (o_dc_req_we) begin
                    cache_mem[o_dc_req_addr] = o_dc_req_wdata;
                end else begin
                    rsp_word = cache_mem.exists(o_dc_req_addr) ?
                               cache_mem[o_dc_req_addr] : fill_word(o_dc_req_addr);
                    rsp_due  = cycle + 1 + int'(next_random() % 4); // 1 to 4 cycles
                end
            end
        end
    end

    // compares the ma/wb register one clock after each completing cycle
    initial begin
        forever begin
            @(negedge clk);
            if (exp_pending) begin
                exp_pending = 1'b0;
                check_word({exp_name, ".pc"}, exp_pc, o_ma_pc);
                check_rdst({exp_name, ".rdst"}, exp_rdst, o_ma_rdst);
                check_word({exp_name, ".alu"}, exp_alu, o_ma_alu_rslt);
                check_wb({exp_name, ".wb"}, exp_wb, o_ma_wb);
                check_word({exp_name, ".mem"}, exp_mem, o_ma_mem_out);
            end
        end
    end

    // one instruction, held until o_miss is low
    task automatic run_op(string name, ma_pkg::ma_ctrl_t ma, ma_pkg::word_t addr,
                          ma_pkg::word_t data, logic fwd, int hold);
        ma_pkg::word_t     pc;
        ma_pkg::reg_addr_t rdst;
        ma_pkg::wb_ctrl_t  wb;
        pc   = next_random() & 32'hffff_fffc;
        rdst = ma_pkg::reg_addr_t'(next_random());
        wb   = ma_pkg::wb_ctrl_t'(next_random());
        @(negedge clk);
        i_ma_ma       = ma;
        i_ma_alu_rslt = addr;
        i_ma_pc       = pc;
        i_ma_rdst     = rdst;
        i_ma_wb       = wb;
        i_op1_mems    = fwd;
        i_ma_mux_wb   = fwd ? data : ~data; // the other source holds a wrong value
        i_ma_rs2_val  = fwd ? ~data : data;
        #5;
        for (int i = 0; i < hold; i++) begin
            if (!o_miss) begin
                $display("o_miss low in %s while credits were withheld", name);
                errors++;
            end
            @(negedge clk);
            #5;
        end
        if (hold > 0) begin
            withhold = 1'b0; // give the credits back
        end
        while (o_miss) begin
            @(negedge clk);
            #5;
        end
        if (addr[31:28] == 4'hF && ma != ma_pkg::MA_NONE && o_dc_req_valid) begin
            $display("register bank access in %s sent a dcache request", name);
            errors++;
        end
        exp_name    = name;
        exp_pc      = pc;
        exp_rdst    = rdst;
        exp_alu     = addr;
        exp_wb      = wb;
        exp_mem     = expected_mem_out(ma, addr);
        exp_pending = 1'b1;
        if (ma == ma_pkg::MA_STORE) begin
            if (addr[31:28] == 4'hF) begin
                shadow_vic[addr[6:2]] = data[3:0];
            end else begin
                shadow_mem[addr] = data;
            end
        end
    endtask

    // vic store under stall, outputs must hold and the bank must not change
    task automatic hold_under_stall(ma_pkg::vic_index_t idx);
        ma_pkg::word_t     pc0;
        ma_pkg::word_t     alu0;
        ma_pkg::word_t     mem0;
        ma_pkg::reg_addr_t rdst0;
        ma_pkg::wb_ctrl_t  wb0;
        @(negedge clk);
        pc0           = o_ma_pc;
        alu0          = o_ma_alu_rslt;
        mem0          = o_ma_mem_out;
        rdst0         = o_ma_rdst;
        wb0           = o_ma_wb;
        i_ma_stall    = 1'b1;
        i_ma_ma       = ma_pkg::MA_STORE;
        i_ma_alu_rslt = {4'hF, 21'd0, idx, 2'b00};
        i_ma_rs2_val  = {28'd0, shadow_vic[idx] ^ 4'hA}; // differs from what is held
        i_op1_mems    = 1'b0;
        i_ma_pc       = next_random();
        i_ma_wb       = 3'b111;
        repeat (4) begin
            @(negedge clk);
            check_word("stall.pc", pc0, o_ma_pc);
            check_rdst("stall.rdst", rdst0, o_ma_rdst);
            check_word("stall.alu", alu0, o_ma_alu_rslt);
            check_wb("stall.wb", wb0, o_ma_wb);
            check_word("stall.mem", mem0, o_ma_mem_out);
        end
        i_ma_ma    = ma_pkg::MA_NONE; // store dropped as the stall ends
        i_ma_stall = 1'b0;
    endtask

    ////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////
    initial begin
        ma_pkg::word_t      addr;
        ma_pkg::ma_ctrl_t   kind;
        ma_pkg::vic_index_t idx;
        int                 assert_fails;
        i_reset        = 1'b1;
        i_ma_wb        = '0;
        i_ma_ma        = ma_pkg::MA_NONE;
        i_ma_alu_rslt  = '0;
        i_ma_rs2_val   = '0;
        i_ma_pc        = '0;
        i_ma_rdst      = '0;
        i_ma_mux_wb    = '0;
        i_op1_mems     = 1'b0;
        i_ma_stall     = 1'b0;
        i_dc_rsp_valid = 1'b0;
        i_dc_rsp_data  = '0;
        i_dc_credit    = 1'b0;
        foreach (shadow_vic[i]) begin
            shadow_vic[i] = '0;
        end
        repeat (2) @(negedge clk); // two rising edges under reset
        i_reset = 1'b0;
        #5;
        check_word("reset.pc", '0, o_ma_pc);
        check_rdst("reset.rdst", '0, o_ma_rdst);
        check_word("reset.alu", '0, o_ma_alu_rslt);
        check_wb("reset.wb", '0, o_ma_wb);
        check_word("reset.mem", '0, o_ma_mem_out);
        if (o_miss) begin
            $display("o_miss high right after reset");
            errors++;
        end
        run_op("no_access", ma_pkg::MA_NONE, next_random(), '0, 1'b0, 0);
        // random stores and loads over eight cache words
        for (int i = 0; i < 120; i++) begin
            addr = 32'h0000_1000 + ((next_random() % 8) << 2);
            kind = (next_random() % 2 == 1) ? ma_pkg::MA_STORE : ma_pkg::MA_LOAD;
            run_op(kind == ma_pkg::MA_STORE ? "cache_store" : "cache_load", kind, addr,
                   next_random(), next_random() % 2 == 1, 0);
        end
        // register bank store then load back
        for (int i = 0; i < 16; i++) begin
            idx  = ma_pkg::vic_index_t'(next_random());
            addr = {4'hF, 21'd0, idx, 2'b00};
            run_op("vic_store", ma_pkg::MA_STORE, addr, next_random(), next_random() % 2 == 1, 0);
            run_op("vic_load", ma_pkg::MA_LOAD, addr, '0, 1'b0, 0);
        end
        // back pressure, start with every credit home
        do begin
            @(negedge clk);
            #5;
        end while (outstanding != 0);
        withhold = 1'b1;
        run_op("bp_store0", ma_pkg::MA_STORE, 32'h0000_2000, next_random(), 1'b0, 0);
        run_op("bp_store1", ma_pkg::MA_STORE, 32'h0000_2004, next_random(), 1'b1, 0);
        run_op("bp_load", ma_pkg::MA_LOAD, 32'h0000_2000, '0, 1'b0, 6);
        run_op("bp_store2", ma_pkg::MA_STORE, 32'h0000_2008, next_random(), 1'b1, 0);
        run_op("bp_readback", ma_pkg::MA_LOAD, 32'h0000_2008, '0, 1'b0, 0);
        // stall hold and blocked bank write
        hold_under_stall(5'd3);
        run_op("stall_readback", ma_pkg::MA_LOAD, {4'hF, 21'd0, 5'd3, 2'b00}, '0, 1'b0, 0);
        repeat (2) @(negedge clk);
        #5;
        assert_fails = u_dut.u_fsm.u_fsm_chk.fail_count + u_dut.u_credit.u_credit_chk.fail_count;
        $display("checks done: %0d compare errors, %0d assertion failures", errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- all.f
src/ma_pkg.sv
src/ma_credit_counter.sv
src/ma_access_fsm.sv
src/ma_vic_regs.sv
src/ma_datapath.sv
src/stage_ma.sv
sim/stage_ma_assert.sv
sim/tb_stage_ma.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_stage_ma -f all.f \
    && ./obj_dir/Vtb_stage_ma +verilator+error+limit+100 > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^Verification passed$" sim.log 2>/dev/null \
    && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed"; exit 1; }
